// ==== include/miner_cfg.svh ====
// gold-miner rope block constants: origin, swing and rope limits, field, values, memory depth
`ifndef MINER_CFG_SVH
`define MINER_CFG_SVH

`define MINER_ORIGIN_X      160
`define MINER_ORIGIN_Y      45

`define MINER_ANGLE_MIN     15
`define MINER_ANGLE_MAX     165
`define MINER_ANGLE_START   165

`define MINER_ROPE_MIN      20
`define MINER_ROPE_STEP     6
`define MINER_ROPE_MAX      275

// playing field seen by the tip
`define MINER_X_LOW         10
`define MINER_X_HIGH        310
`define MINER_Y_HIGH        230

`define MINER_BOX           16

`define MINER_VALUE_STONE   1
`define MINER_VALUE_GOLD    2
`define MINER_VALUE_DIAMOND 5

`define MINER_OBJECTS       16
`define MINER_HOLD_FRAMES   3   // pause after scoring

`endif

// ==== logic/frame_pacer.sv ====
// frame tick divider with a go key latch that lives until the next tick
`default_nettype none

module frame_pacer #(
    parameter int frame_cycles = 64
) (
    input  wire logic clock,
    input  wire logic resetn,
    input  wire logic enable,
    input  wire logic go_key,
    output logic      frame_tick,
    output logic      go_pending
);
    localparam int count_width = (frame_cycles > 1) ? $clog2(frame_cycles) : 1;

    logic [count_width-1:0] count;
    logic                   go_key_q;
    logic                   go_rise;

    assign go_rise = go_key && !go_key_q;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            count      <= '0;
            frame_tick <= 1'b0;
            go_key_q   <= 1'b0;
            go_pending <= 1'b0;
        end else begin
            go_key_q   <= go_key;
            // drops the cycle after a tick, a fresh press wins
            go_pending <= (go_pending && !frame_tick) || go_rise;
            frame_tick <= 1'b0;
            if (enable) begin
                if (count == count_width'(frame_cycles - 1)) begin
                    count      <= '0;
                    frame_tick <= 1'b1;
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

    assert property (@(posedge clock) disable iff (!resetn) frame_tick |=> !frame_tick);

endmodule

`default_nettype wire

// ==== logic/miner_pkg.sv ====
// shared object, memory request, tip, trig and phase types of the rope block
`default_nettype none

package miner_pkg;

    typedef enum logic [1:0] {
        stone,
        gold,
        diamond
    } object_kind_e;

    typedef struct packed {
        logic [8:0]   x;
        logic [7:0]   y;        // top-left corner
        object_kind_e kind;
        logic         visible;
        logic         hooked;
    } object_entry_t;

    typedef struct packed {
        logic          write;
        logic [3:0]    index;
        object_entry_t entry;
    } mem_req_t;

    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
    } rope_tip_t;

    typedef struct packed {
        logic [8:0] sin_mag;
        logic [8:0] cos_mag;
        logic       cos_negative;   // above 90 degrees
    } trig_t;

    typedef enum logic [2:0] {
        stopped,
        swing_ccw,
        swing_cw,
        lower,
        scan,
        raise,
        hold
    } rope_phase_e;

endpackage

`default_nettype wire

// ==== logic/miner_top.sv ====
// rope block top: frame pacer, trig table, rope FSM, arbiter and object memory
`default_nettype none

module miner_top #(
    parameter int frame_cycles = 64
) (
    input  wire logic                clock,
    input  wire logic                resetn,
    input  wire logic                enable,
    input  wire logic                go_key,
    input  wire logic [4:0]          object_count,
    input  wire logic                host_valid,
    input  wire miner_pkg::mem_req_t host_req,
    output miner_pkg::object_entry_t host_rdata,
    output logic [7:0]               angle,
    output logic [9:0]               rope_len,
    output miner_pkg::rope_tip_t     tip,
    output miner_pkg::rope_phase_e   phase,
    output logic [9:0]               score
);
    import miner_pkg::*;

    logic          frame_tick;
    logic          go_pending;
    logic          rope_valid;
    logic          rope_grant;
    logic          mem_enable;
    trig_t         trig;
    mem_req_t      rope_req;
    mem_req_t      mem_req;
    object_entry_t rope_rdata;
    object_entry_t mem_rdata;

    frame_pacer #(
        .frame_cycles(frame_cycles)
    ) pacer_i (
        .clock      (clock),
        .resetn     (resetn),
        .enable     (enable),
        .go_key     (go_key),
        .frame_tick (frame_tick),
        .go_pending (go_pending)
    );

    trig_table trig_i (
        .angle (angle),
        .trig  (trig)
    );

    rope_controller rope_i (
        .clock        (clock),
        .resetn       (resetn),
        .enable       (enable),
        .frame_tick   (frame_tick),
        .go_pending   (go_pending),
        .object_count (object_count),
        .trig         (trig),
        .rope_grant   (rope_grant),
        .rope_rdata   (rope_rdata),
        .rope_valid   (rope_valid),
        .rope_req     (rope_req),
        .angle        (angle),
        .rope_len     (rope_len),
        .tip          (tip),
        .phase        (phase),
        .score        (score)
    );

    ram_arbiter arbiter_i (
        .clock      (clock),
        .resetn     (resetn),
        .host_valid (host_valid),
        .rope_valid (rope_valid),
        .host_req   (host_req),
        .rope_req   (rope_req),
        .rope_grant (rope_grant),
        .host_rdata (host_rdata),
        .rope_rdata (rope_rdata),
        .mem_enable (mem_enable),
        .mem_req    (mem_req),
        .mem_rdata  (mem_rdata)
    );

    object_ram ram_i (
        .clock  (clock),
        .resetn (resetn),
        .enable (mem_enable),
        .req    (mem_req),
        .rdata  (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== logic/object_ram.sv ====
// single-port object memory, write-first synchronous read, cleared by a sweep after reset
`default_nettype none
`include "miner_cfg.svh"

module object_ram (
    input  wire logic                clock,
    input  wire logic                resetn,
    input  wire logic                enable,
    input  wire miner_pkg::mem_req_t req,
    output miner_pkg::object_entry_t rdata
);
    import miner_pkg::*;

    localparam int depth = `MINER_OBJECTS;

    object_entry_t mem [depth];
    logic [3:0]    sweep_index;
    logic          sweep_active;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            sweep_active <= 1'b1;
            sweep_index  <= '0;
        end else if (sweep_active) begin
            mem[sweep_index] <= '0;
            sweep_index      <= sweep_index + 4'd1;
            if (sweep_index == 4'(depth - 1)) sweep_active <= 1'b0;
        end else if (enable) begin
            if (req.write) begin
                mem[req.index] <= req.entry;
                rdata          <= req.entry;    // write-first
            end else begin
                rdata <= mem[req.index];
            end
        end
    end

    // requesters have to wait out the clear
    assert property (@(posedge clock) disable iff (!resetn) sweep_active |-> !enable);

endmodule

`default_nettype wire

// ==== logic/ram_arbiter.sv ====
// object memory arbiter with host priority that steers read data back to whoever asked
`default_nettype none

module ram_arbiter (
    input  wire logic                     clock,
    input  wire logic                     resetn,
    input  wire logic                     host_valid,
    input  wire logic                     rope_valid,
    input  wire miner_pkg::mem_req_t      host_req,
    input  wire miner_pkg::mem_req_t      rope_req,
    output logic                          rope_grant,
    output miner_pkg::object_entry_t      host_rdata,
    output miner_pkg::object_entry_t      rope_rdata,
    output logic                          mem_enable,
    output miner_pkg::mem_req_t           mem_req,
    input  wire miner_pkg::object_entry_t mem_rdata
);
    import miner_pkg::*;

    logic          host_read_q;     // memory output belongs to the host this cycle
    logic          rope_read_q;
    object_entry_t host_keep;
    object_entry_t rope_keep;

    assign rope_grant = rope_valid && !host_valid;
    assign mem_enable = host_valid || rope_grant;
    assign mem_req    = host_valid ? host_req : rope_req;
    assign host_rdata = host_read_q ? mem_rdata : host_keep;
    assign rope_rdata = rope_read_q ? mem_rdata : rope_keep;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            host_read_q <= 1'b0;
            rope_read_q <= 1'b0;
        end else begin
            host_read_q <= host_valid && !host_req.write;
            rope_read_q <= rope_grant && !rope_req.write;
        end
    end

    // last read data held between reads
    always_ff @(posedge clock) begin
        if (host_read_q) host_keep <= mem_rdata;
        if (rope_read_q) rope_keep <= mem_rdata;
    end

    // a rope request held off by the host is still there next cycle
    assert property (@(posedge clock) disable iff (!resetn)
        rope_valid && host_valid |=> rope_valid && $stable(rope_req));

endmodule

`default_nettype wire

// ==== logic/rope_controller.sv ====
// rope state machine: swing, lower, scan for a catch, raise with the prize and score it
`default_nettype none
`include "miner_cfg.svh"

module rope_controller (
    input  wire logic                     clock,
    input  wire logic                     resetn,
    input  wire logic                     enable,
    input  wire logic                     frame_tick,
    input  wire logic                     go_pending,
    input  wire logic [4:0]               object_count,
    input  wire miner_pkg::trig_t         trig,
    input  wire logic                     rope_grant,
    input  wire miner_pkg::object_entry_t rope_rdata,
    output logic                          rope_valid,
    output miner_pkg::mem_req_t           rope_req,
    output logic [7:0]                    angle,
    output logic [9:0]                    rope_len,
    output miner_pkg::rope_tip_t          tip,
    output miner_pkg::rope_phase_e        phase,
    output logic [9:0]                    score
);
    import miner_pkg::*;

    typedef enum logic [1:0] {op_none, op_read, op_data, op_write} op_e;

    localparam logic [9:0] len_min   = 10'(`MINER_ROPE_MIN);
    localparam logic [9:0] len_step  = 10'(`MINER_ROPE_STEP);
    localparam logic [9:0] len_max   = 10'(`MINER_ROPE_MAX);
    localparam logic [7:0] angle_min = 8'(`MINER_ANGLE_MIN);
    localparam logic [7:0] angle_max = 8'(`MINER_ANGLE_MAX);
    localparam logic [1:0] hold_last = 2'(`MINER_HOLD_FRAMES - 1);

    op_e           op;
    logic          dir_cw;      // swing to resume after the rope comes back
    logic          hooked;
    logic [3:0]    scan_index;
    logic [3:0]    hook_index;
    logic [1:0]    hold_count;
    object_entry_t held;        // local copy of the hooked object

    rope_tip_t     tip_lower;
    logic [9:0]    len_down;
    logic [9:0]    len_up;
    logic          step_now;
    logic          hit;
    logic [11:0]   back_x_full;
    logic [11:0]   back_y_full;
    object_entry_t hit_entry;
    object_entry_t moved;
    object_entry_t cleared;

    function automatic rope_tip_t tip_of(input logic [9:0] len, input trig_t t);
        logic [18:0] px;
        logic [18:0] py;
        rope_tip_t   r;
        px  = len * t.cos_mag;
        py  = len * t.sin_mag;
        r.x = t.cos_negative ? 10'(`MINER_ORIGIN_X) - px[17:8]
                             : 10'(`MINER_ORIGIN_X) + px[17:8];
        r.y = 10'(`MINER_ORIGIN_Y) + py[17:8];
        return r;
    endfunction

    // x below zero wraps high and counts as outside too
    function automatic logic outside(input rope_tip_t p);
        return p.x <= 10'(`MINER_X_LOW) || p.x >= 10'(`MINER_X_HIGH)
            || p.y >= 10'(`MINER_Y_HIGH);
    endfunction

    function automatic logic [9:0] value_of(input object_kind_e k);
        case (k)
            gold:    return 10'(`MINER_VALUE_GOLD);
            diamond: return 10'(`MINER_VALUE_DIAMOND);
            default: return 10'(`MINER_VALUE_STONE);
        endcase
    endfunction

    assign tip       = tip_of(rope_len, trig);
    assign len_down  = rope_len + len_step;
    assign len_up    = rope_len - len_step;
    assign tip_lower = tip_of(len_down, trig);
    assign step_now  = enable && frame_tick && op == op_none;

    // box is half open, x .. x+15 and y .. y+15
    assign hit = rope_rdata.visible && !rope_rdata.hooked
              && tip.x >= 10'(rope_rdata.x) && tip.x < 10'(rope_rdata.x) + 10'(`MINER_BOX)
              && tip.y >= 10'(rope_rdata.y) && tip.y < 10'(rope_rdata.y) + 10'(`MINER_BOX);

    // one rope step back toward the origin
    assign back_x_full = 12'(`MINER_ROPE_STEP) * trig.cos_mag;
    assign back_y_full = 12'(`MINER_ROPE_STEP) * trig.sin_mag;

    always_comb begin
        hit_entry        = rope_rdata;
        hit_entry.hooked = 1'b1;
        moved            = held;
        moved.x          = trig.cos_negative ? held.x + 9'(back_x_full[11:8])
                                             : held.x - 9'(back_x_full[11:8]);
        moved.y          = held.y - 8'(back_y_full[11:8]);
        cleared          = held;
        cleared.visible  = 1'b0;
        cleared.hooked   = 1'b0;
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            phase      <= stopped;
            angle      <= 8'(`MINER_ANGLE_START);
            rope_len   <= len_min;
            score      <= '0;
            op         <= op_none;
            dir_cw     <= 1'b0;
            hooked     <= 1'b0;
            scan_index <= '0;
            hook_index <= '0;
            hold_count <= '0;
            rope_valid <= 1'b0;
        end else begin
            if (rope_valid && rope_grant) begin
                rope_valid <= 1'b0;
                op         <= (op == op_read) ? op_data : op_none;
            end
            case (phase)
                stopped: begin
                    if (enable) phase <= swing_ccw;
                end
                swing_ccw, swing_cw: begin
                    if (step_now) begin
                        if (go_pending) begin
                            phase  <= lower;
                            dir_cw <= (phase == swing_cw);
                        end else if (phase == swing_ccw) begin
                            angle <= angle - 8'd1;
                            if (angle == angle_min + 8'd1) phase <= swing_cw;
                        end else begin
                            angle <= angle + 8'd1;
                            if (angle == angle_max - 8'd1) phase <= swing_ccw;
                        end
                    end
                end
                lower: begin
                    if (step_now) begin
                        rope_len <= len_down;
                        if (outside(tip_lower) || len_down >= len_max) begin
                            phase <= raise;
                        end else if (object_count != 5'd0) begin
                            phase      <= scan;
                            scan_index <= '0;
                            rope_req   <= '{write: 1'b0, index: 4'd0, entry: '0};
                            rope_valid <= 1'b1;
                            op         <= op_read;
                        end
                    end
                end
                scan: begin
                    if (op == op_data) begin
                        if (hit) begin
                            held       <= hit_entry;
                            hooked     <= 1'b1;
                            hook_index <= scan_index;
                            rope_req   <= '{write: 1'b1, index: scan_index, entry: hit_entry};
                            rope_valid <= 1'b1;
                            op         <= op_write;
                        end else if ({1'b0, scan_index} + 5'd1 >= object_count) begin
                            phase <= lower;
                            op    <= op_none;
                        end else begin
                            scan_index <= scan_index + 4'd1;
                            rope_req   <= '{write: 1'b0, index: scan_index + 4'd1, entry: '0};
                            rope_valid <= 1'b1;
                            op         <= op_read;
                        end
                    end else if (op == op_write && rope_grant) begin
                        phase <= raise;
                    end
                end
                raise: begin
                    if (step_now) begin
                        if (rope_len <= len_min + len_step) begin
                            rope_len <= len_min;
                            if (hooked) begin
                                phase      <= hold;
                                hold_count <= '0;
                                hooked     <= 1'b0;
                                score      <= score + value_of(held.kind);
                                rope_req   <= '{write: 1'b1, index: hook_index, entry: cleared};
                                rope_valid <= 1'b1;
                                op         <= op_write;
                            end else begin
                                phase <= dir_cw ? swing_cw : swing_ccw;
                            end
                        end else begin
                            rope_len <= len_up;
                            if (hooked) begin
                                held       <= moved;
                                rope_req   <= '{write: 1'b1, index: hook_index, entry: moved};
                                rope_valid <= 1'b1;
                                op         <= op_write;
                            end
                        end
                    end
                end
                hold: begin
                    if (step_now) begin
                        if (hold_count == hold_last) phase <= dir_cw ? swing_cw : swing_ccw;
                        else hold_count <= hold_count + 2'd1;
                    end
                end
                default: phase <= stopped;
            endcase
        end
    end

    assert property (@(posedge clock) disable iff (!resetn)
        angle >= angle_min && angle <= angle_max);

    assert property (@(posedge clock) disable iff (!resetn) rope_len >= len_min);

    // request held still until the arbiter takes it
    assert property (@(posedge clock) disable iff (!resetn)
        rope_valid && !rope_grant |=> rope_valid && $stable(rope_req));

endmodule

`default_nettype wire

// ==== logic/trig_table.sv ====
// sine and cosine magnitudes for 0 to 180 degrees, scaled by 256
`default_nettype none

module trig_table (
    input  wire logic [7:0]  angle,
    output miner_pkg::trig_t trig
);
    // round(256 * sin(d)) for d = 0 .. 90
    localparam logic [8:0] sin_lut [0:90] = '{
        9'd0,   9'd4,   9'd9,   9'd13,  9'd18,  9'd22,  9'd27,  9'd31,  9'd36,  9'd40,
        9'd44,  9'd49,  9'd53,  9'd58,  9'd62,  9'd66,  9'd71,  9'd75,  9'd79,  9'd83,
        9'd88,  9'd92,  9'd96,  9'd100, 9'd104, 9'd108, 9'd112, 9'd116, 9'd120, 9'd124,
        9'd128, 9'd132, 9'd136, 9'd139, 9'd143, 9'd147, 9'd150, 9'd154, 9'd158, 9'd161,
        9'd165, 9'd168, 9'd171, 9'd175, 9'd178, 9'd181, 9'd184, 9'd187, 9'd190, 9'd193,
        9'd196, 9'd199, 9'd202, 9'd204, 9'd207, 9'd210, 9'd212, 9'd215, 9'd217, 9'd219,
        9'd222, 9'd224, 9'd226, 9'd228, 9'd230, 9'd232, 9'd234, 9'd236, 9'd237, 9'd239,
        9'd241, 9'd242, 9'd243, 9'd245, 9'd246, 9'd247, 9'd248, 9'd249, 9'd250, 9'd251,
        9'd252, 9'd253, 9'd254, 9'd254, 9'd255, 9'd255, 9'd255, 9'd256, 9'd256, 9'd256,
        9'd256
    };

    logic [7:0] clamped;
    logic [6:0] sin_index;
    logic [6:0] cos_index;

    assign clamped = (angle > 8'd180) ? 8'd180 : angle;

    always_comb begin
        if (clamped > 8'd90) begin
            sin_index = 7'(8'd180 - clamped);
            cos_index = 7'(clamped - 8'd90);
        end else begin
            sin_index = 7'(clamped);
            cos_index = 7'(8'd90 - clamped);    // cos(a) = sin(90 - a)
        end
        trig.sin_mag      = sin_lut[sin_index];
        trig.cos_mag      = sin_lut[cos_index];
        trig.cos_negative = clamped > 8'd90;
    end

endmodule

`default_nettype wire

// ==== testbench/clock_gen.sv ====
// testbench clock source, period 20, with resetn held low for the first 5 cycles
`default_nettype none

module clock_gen (
    output logic clock,
    output logic resetn
);
    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    initial begin
        resetn = 1'b0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        resetn = 1'b1;
    end

endmodule

`default_nettype wire

// ==== testbench/miner_tb.sv ====
// directed tests of the rope block covering swing, host access, miss, catch, scoring and contention
`default_nettype none

module miner_tb;
    import miner_pkg::*;

    localparam int frame_cycles   = 64;
    localparam int frame_budget   = 600;    // all test frames with margin
    localparam int timeout_cycles = frame_budget * frame_cycles + 1600;

    logic          clock;
    logic          resetn;
    logic          enable;
    logic          go_key;
    logic [4:0]    object_count;
    logic          host_valid;
    mem_req_t      host_req;
    object_entry_t host_rdata;
    logic [7:0]    angle;
    logic [9:0]    rope_len;
    rope_tip_t     tip;
    rope_phase_e   phase;
    logic [9:0]    score;

    int checks;
    int errors;
    int test_base;
    int cycles;
    int seed;
    int plain_scan;
    int busy_scan;

    clock_gen clock_i (.clock(clock), .resetn(resetn));

    miner_top #(.frame_cycles(frame_cycles)) dut_i (
        .clock(clock), .resetn(resetn), .enable(enable), .go_key(go_key),
        .object_count(object_count), .host_valid(host_valid), .host_req(host_req),
        .host_rdata(host_rdata), .angle(angle), .rope_len(rope_len), .tip(tip),
        .phase(phase), .score(score)
    );

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles == timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic check_value(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name);
        $display("%s finished with %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    task automatic host_write(input logic [3:0] index, input object_entry_t entry);
        @(negedge clock);
        host_valid = 1'b1;
        host_req   = '{write: 1'b1, index: index, entry: entry};
        @(negedge clock);
        host_valid = 1'b0;
    endtask

    task automatic host_read(input logic [3:0] index, output object_entry_t entry);
        @(negedge clock);
        host_valid = 1'b1;
        host_req   = '{write: 1'b0, index: index, entry: '0};
        @(negedge clock);
        host_valid = 1'b0;
        entry      = host_rdata;     // data lands one cycle after the grant
    endtask

    function automatic logic swinging();
        return phase == swing_ccw || phase == swing_cw;
    endfunction

    task automatic go_at_90();
        while (!(swinging() && angle == 8'd90)) @(negedge clock);
        go_key = 1'b1;
        @(negedge clock);
        go_key = 1'b0;
        while (phase != lower) @(negedge clock);
    endtask

    // tip at 90 degrees is x 160, y 45 plus rope_len
    function automatic int catch_len(input int box_y);
        int len;
        len = 20;
        do len += 6; while (!(45 + len >= box_y && 45 + len < box_y + 16));
        return len;
    endfunction

    task automatic test_swing();
        int prev;
        check_value("angle", angle, 165);
        check_value("rope_len", rope_len, 20);
        check_value("score", score, 0);
        check_value("phase", phase, stopped);
        enable = 1'b1;
        prev   = angle;
        do begin
            while (angle == prev) @(negedge clock);
            check_value("angle", angle, prev - 1);
            prev = angle;
        end while (angle != 15);
        while (angle == prev) @(negedge clock);
        check_value("angle", angle, 16);        // turned around
        report_test("swing");
    endtask

    task automatic test_host();
        object_entry_t wr [4];
        object_entry_t rd;
        for (int i = 0; i < 4; i++) begin
            wr[i].x       = 9'($random(seed));
            wr[i].y       = 8'($random(seed));
            wr[i].kind    = object_kind_e'(2'($unsigned($random(seed)) % 3));
            wr[i].visible = 1'($random(seed));
            wr[i].hooked  = 1'b0;
            host_write(4'(i), wr[i]);
        end
        for (int i = 0; i < 4; i++) begin
            host_read(4'(i), rd);
            check_value("host_rdata", rd, wr[i]);
        end
        report_test("host");
    endtask

    task automatic run_miss(input string name);
        int prev;
        int start_score;
        start_score = score;
        go_at_90();
        prev = 20;
        do begin
            while (rope_len == prev) @(negedge clock);
            check_value("rope_len", rope_len, prev + 6);
            check_value("tip.x", tip.x, 160);
            check_value("tip.y", tip.y, 45 + prev + 6);
            prev = rope_len;
        end while (!(prev >= 275 || 45 + prev >= 230));
        check_value("phase", phase, raise);
        while (!swinging()) @(negedge clock);
        check_value("rope_len", rope_len, 20);
        check_value("score", score, start_score);
        report_test(name);
    endtask

    task automatic lower_until_raise(input bit contend, output int scan_cycles);
        int burst;
        burst       = 0;
        scan_cycles = 0;
        while (phase != raise) begin
            @(negedge clock);
            host_valid = 1'b0;
            if (phase == scan) begin
                scan_cycles++;
                if (contend && burst < 6) begin
                    host_valid = 1'b1;
                    host_req   = '{write: 1'b0, index: 4'(burst), entry: '0};
                    burst++;
                end
            end else begin
                burst = 0;
            end
        end
        host_valid = 1'b0;
    endtask

    task automatic run_catch(input string name, input object_kind_e kind, input int value,
                             input bit contend, output int scan_cycles);
        object_entry_t obj;
        object_entry_t rd;
        int            start_score;
        int            y_exp;
        int            prev;
        obj          = '{x: 9'd152, y: 8'd120, kind: kind, visible: 1'b1, hooked: 1'b0};
        start_score  = score;
        object_count = 5'd1;
        host_write(4'd0, obj);
        go_at_90();
        lower_until_raise(contend, scan_cycles);
        check_value("rope_len", rope_len, catch_len(120));
        host_read(4'd0, rd);
        check_value("host_rdata.hooked", rd.hooked, 1);
        y_exp = 120;
        forever begin
            prev = rope_len;
            while (rope_len == prev) @(negedge clock);
            if (phase != raise) break;
            repeat (4) @(negedge clock);
            host_read(4'd0, rd);
            y_exp -= 6;
            check_value("host_rdata.y", rd.y, y_exp);
        end
        while (!swinging()) @(negedge clock);
        check_value("score", score, start_score + value);
        host_read(4'd0, rd);
        check_value("host_rdata.visible", rd.visible, 0);
        check_value("host_rdata.hooked", rd.hooked, 0);
        report_test(name);
    endtask

    initial begin
        enable       = 1'b0;
        go_key       = 1'b0;
        object_count = 5'd0;
        host_valid   = 1'b0;
        host_req     = '0;
        checks       = 0;
        errors       = 0;
        test_base    = 0;
        cycles       = 0;
        seed         = 60252;
        @(posedge resetn);
        @(negedge clock);
        test_swing();
        test_host();
        run_miss("miss");
        run_catch("catch gold", gold, 2, 1'b0, plain_scan);
        run_catch("catch diamond", diamond, 5, 1'b0, busy_scan);
        run_catch("catch stone", stone, 1, 1'b0, busy_scan);
        object_count = 5'd1;                    // entry 0 is now invisible
        run_miss("invisible");
        run_catch("contention", gold, 2, 1'b1, busy_scan);
        checks++;
        if (busy_scan <= plain_scan) begin
            errors++;
            $display("contended scan was not slower than the plain one");
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
logic/miner_pkg.sv
logic/frame_pacer.sv
logic/trig_table.sv
logic/object_ram.sv
logic/ram_arbiter.sv
logic/rope_controller.sv
logic/miner_top.sv
testbench/clock_gen.sv
testbench/miner_tb.sv
